//--- include/tti_config.svh
// Build-time sizes for the TTI data path, included by the packages and the RTL
`ifndef TTI_CONFIG_SVH
`define TTI_CONFIG_SVH

// Register and queue word width
`define TTI_DATA_W 32

// Entries per data queue
`define TTI_QUEUE_DEPTH 16

// Register address code width
`define TTI_ADDR_W 4

// Ready threshold field width, one field per queue
`define TTI_THLD_W 8

`endif

//--- rtl/tti_csr_pkg.sv
// Register map of the TTI software port with request, operation and response types
`include "tti_config.svh"

package tti_csr_pkg;

  typedef enum logic [`TTI_ADDR_W-1:0] {
    TX_DATA_PORT    = `TTI_ADDR_W'(0),
    RX_DATA_PORT    = `TTI_ADDR_W'(1),
    QUEUE_THLD_CTRL = `TTI_ADDR_W'(2),
    RESET_CONTROL   = `TTI_ADDR_W'(3),
    QUEUE_STATUS    = `TTI_ADDR_W'(4)
  } csr_addr_e;

  // QUEUE_THLD_CTRL layout
  typedef struct packed {
    logic [`TTI_DATA_W-2*`TTI_THLD_W-1:0] reserved;
    logic [`TTI_THLD_W-1:0]               tx_ready_thld;
    logic [`TTI_THLD_W-1:0]               rx_ready_thld;
  } thld_view_t;

  typedef union packed {
    logic [`TTI_DATA_W-1:0] raw;
    thld_view_t             thld;
  } csr_word_u;

  typedef struct packed {
    logic                   write;
    csr_addr_e              addr;
    logic [`TTI_DATA_W-1:0] wdata;
  } csr_req_t;

  // One bit per operation, exactly one set
  typedef struct packed {
    logic push_tx;
    logic pop_rx;
    logic wr_thld;
    logic rd_thld;
    logic wr_rst;
    logic rd_status;
    logic bad;
  } op_kind_t;

  typedef struct packed {
    op_kind_t  kind;
    csr_word_u wdata;
  } csr_op_t;

  typedef struct packed {
    logic                   err;
    logic [`TTI_DATA_W-1:0] rdata;
  } csr_rsp_t;

endpackage

//--- rtl/tti_queue_pkg.sv
// Data queue entry, depth and status types shared by the queues and their users
`include "tti_config.svh"

package tti_queue_pkg;

  // Count range is 0 to depth inclusive
  localparam int unsigned depth_w = $clog2(`TTI_QUEUE_DEPTH + 1);

  typedef logic [`TTI_DATA_W-1:0] queue_word_t;

  typedef logic [depth_w-1:0] queue_depth_t;

  typedef struct packed {
    queue_depth_t depth;
    logic         empty;
    logic         full;
    logic         ready_thld_trig;
  } queue_status_t;

endpackage

//--- rtl/tti_csr_decode.sv
// Register request stage: takes a request and registers it as a decoded operation
`timescale 1ns/10ps
`include "tti_config.svh"

module tti_csr_decode (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic                  req_valid_i,
  input  tti_csr_pkg::csr_req_t req_i,
  output logic                  req_ready_o,
  output logic                  op_valid_o,
  output tti_csr_pkg::csr_op_t  op_o,
  input  logic                  op_ready_i
);
  import tti_csr_pkg::*;

  logic     op_valid_q;
  csr_op_t  op_q;
  op_kind_t kind_d;

  // Slot is free when empty or drained this cycle
  assign req_ready_o = !op_valid_q || op_ready_i;

  always_comb begin
    kind_d = '0;
    case (req_i.addr)
      TX_DATA_PORT:    kind_d.push_tx   = req_i.write;
      RX_DATA_PORT:    kind_d.pop_rx    = !req_i.write;
      QUEUE_THLD_CTRL: begin
        kind_d.wr_thld = req_i.write;
        kind_d.rd_thld = !req_i.write;
      end
      RESET_CONTROL:   kind_d.wr_rst    = req_i.write;
      QUEUE_STATUS:    kind_d.rd_status = !req_i.write;
      default:         kind_d.bad       = 1'b1;
    endcase
    // Wrong direction on a known code
    if (kind_d == '0) begin
      kind_d.bad = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      op_valid_q <= 1'b0;
    end else if (req_ready_o) begin
      op_valid_q <= req_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      op_q.kind  <= kind_d;
      op_q.wdata <= req_i.wdata;
    end
  end

  assign op_valid_o = op_valid_q;
  assign op_o       = op_q;

endmodule

//--- rtl/tti_csr_access.sv
// Register access stage: runs decoded operations against the queues and returns responses
`timescale 1ns/10ps
`include "tti_config.svh"

module tti_csr_access (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         op_valid_i,
  input  tti_csr_pkg::csr_op_t         op_i,
  output logic                         op_ready_o,
  output logic                         rsp_valid_o,
  output tti_csr_pkg::csr_rsp_t        rsp_o,
  input  logic                         rsp_ready_i,
  output logic                         tx_push_o,
  output logic                         tx_flush_o,
  output tti_queue_pkg::queue_word_t   tx_wdata_o,
  input  tti_queue_pkg::queue_status_t tx_status_i,
  output logic                         rx_pop_o,
  output logic                         rx_flush_o,
  input  tti_queue_pkg::queue_word_t   rx_head_i,
  input  tti_queue_pkg::queue_status_t rx_status_i,
  output logic [`TTI_THLD_W-1:0]       tx_thld_o,
  output logic [`TTI_THLD_W-1:0]       rx_thld_o
);
  import tti_csr_pkg::*;

  logic      exec;
  logic      rsp_valid_q;
  csr_rsp_t  rsp_q;
  csr_rsp_t  rsp_d;
  csr_word_u thld_q;
  csr_word_u thld_d;

  // Response slot is free when empty or being taken
  assign op_ready_o = !rsp_valid_q || rsp_ready_i;
  assign exec       = op_valid_i && op_ready_o;

  // Queue strobes fire on the execute edge
  assign tx_push_o  = exec && op_i.kind.push_tx && !tx_status_i.full;
  assign rx_pop_o   = exec && op_i.kind.pop_rx && !rx_status_i.empty;
  assign tx_flush_o = exec && op_i.kind.wr_rst && op_i.wdata.raw[0];
  assign rx_flush_o = exec && op_i.kind.wr_rst && op_i.wdata.raw[1];
  assign tx_wdata_o = op_i.wdata.raw;

  always_comb begin
    rsp_d  = '0;
    thld_d = '0;
    thld_d.thld.rx_ready_thld = op_i.wdata.thld.rx_ready_thld;
    thld_d.thld.tx_ready_thld = op_i.wdata.thld.tx_ready_thld;
    if (op_i.kind.push_tx) begin
      rsp_d.err = tx_status_i.full;
    end
    if (op_i.kind.pop_rx) begin
      rsp_d.err   = rx_status_i.empty;
      rsp_d.rdata = rx_status_i.empty ? '0 : rx_head_i;
    end
    if (op_i.kind.rd_thld) begin
      rsp_d.rdata = thld_q.raw;
    end
    if (op_i.kind.rd_status) begin
      rsp_d.rdata[7:0]  = 8'(rx_status_i.depth);
      rsp_d.rdata[15:8] = 8'(tx_status_i.depth);
      rsp_d.rdata[16]   = rx_status_i.empty;
      rsp_d.rdata[17]   = tx_status_i.full;
    end
    if (op_i.kind.bad) begin
      rsp_d.err = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      thld_q <= '0;
    end else if (exec && op_i.kind.wr_thld) begin
      thld_q <= thld_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
    end else if (op_ready_o) begin
      rsp_valid_q <= op_valid_i;
    end
  end

  // Held while the response waits
  always_ff @(posedge clk_i) begin
    if (exec) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;
  assign tx_thld_o   = thld_q.thld.tx_ready_thld;
  assign rx_thld_o   = thld_q.thld.rx_ready_thld;

endmodule

//--- rtl/tti_queue.sv
// First-word-fall-through data queue with flush and ready threshold, used for TX and RX
`timescale 1ns/10ps
`include "tti_config.svh"

module tti_queue (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         push_i,
  input  tti_queue_pkg::queue_word_t   wdata_i,
  input  logic                         pop_i,
  output tti_queue_pkg::queue_word_t   rdata_o,
  input  logic                         flush_i,
  input  logic [`TTI_THLD_W-1:0]       thld_i,
  output tti_queue_pkg::queue_status_t status_o
);
  import tti_queue_pkg::*;

  localparam int unsigned ptr_w = $clog2(`TTI_QUEUE_DEPTH);
  localparam logic [ptr_w-1:0] last_ptr = ptr_w'(`TTI_QUEUE_DEPTH - 1);

  queue_word_t              mem [`TTI_QUEUE_DEPTH];
  logic [ptr_w-1:0]         wr_ptr_q;
  logic [ptr_w-1:0]         rd_ptr_q;
  queue_depth_t             depth_q;
  logic                     empty;
  logic                     full;
  logic                     do_push;
  logic                     do_pop;
  logic [`TTI_THLD_W-1:0]   depth_ext;

  assign empty = (depth_q == '0);
  assign full  = (depth_q == queue_depth_t'(`TTI_QUEUE_DEPTH));

  // Flush wins over both ports
  assign do_push = push_i && !full && !flush_i;
  assign do_pop  = pop_i && !empty && !flush_i;

  always_ff @(posedge clk_i) begin
    if (rst_i || flush_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      depth_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == last_ptr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == last_ptr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   depth_q <= depth_q + 1'b1;
        2'b01:   depth_q <= depth_q - 1'b1;
        default: depth_q <= depth_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr_q] <= wdata_i;
    end
  end

  // Head word is visible without a pop
  assign rdata_o = mem[rd_ptr_q];

  assign depth_ext = {{(`TTI_THLD_W - depth_w){1'b0}}, depth_q};

  assign status_o.depth           = depth_q;
  assign status_o.empty           = empty;
  assign status_o.full            = full;
  assign status_o.ready_thld_trig = (thld_i != '0) && (depth_ext >= thld_i);

endmodule

//--- rtl/tti_top.sv
// TTI data path top: register port pipeline plus TX and RX data queues for the controller
`timescale 1ns/10ps
`include "tti_config.svh"

module tti_top (
  input  logic                         clk_i,
  input  logic                         rst_i,
  input  logic                         csr_req_valid_i,
  input  tti_csr_pkg::csr_req_t        csr_req_i,
  output logic                         csr_req_ready_o,
  output logic                         csr_rsp_valid_o,
  output tti_csr_pkg::csr_rsp_t        csr_rsp_o,
  input  logic                         csr_rsp_ready_i,
  output logic                         tx_rvalid_o,
  input  logic                         tx_rready_i,
  output tti_queue_pkg::queue_word_t   tx_rdata_o,
  input  logic                         rx_wvalid_i,
  output logic                         rx_wready_o,
  input  tti_queue_pkg::queue_word_t   rx_wdata_i,
  output tti_queue_pkg::queue_status_t tx_status_o,
  output tti_queue_pkg::queue_status_t rx_status_o
);
  import tti_csr_pkg::*;
  import tti_queue_pkg::*;

  logic                   op_valid;
  logic                   op_ready;
  csr_op_t                op;
  logic                   tx_push;
  logic                   tx_flush;
  queue_word_t            tx_wdata;
  logic                   rx_pop;
  logic                   rx_flush;
  queue_word_t            rx_head;
  logic [`TTI_THLD_W-1:0] tx_thld;
  logic [`TTI_THLD_W-1:0] rx_thld;

  tti_csr_decode u_decode (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_valid_i (csr_req_valid_i),
    .req_i       (csr_req_i),
    .req_ready_o (csr_req_ready_o),
    .op_valid_o  (op_valid),
    .op_o        (op),
    .op_ready_i  (op_ready)
  );

  tti_csr_access u_access (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .op_valid_i  (op_valid),
    .op_i        (op),
    .op_ready_o  (op_ready),
    .rsp_valid_o (csr_rsp_valid_o),
    .rsp_o       (csr_rsp_o),
    .rsp_ready_i (csr_rsp_ready_i),
    .tx_push_o   (tx_push),
    .tx_flush_o  (tx_flush),
    .tx_wdata_o  (tx_wdata),
    .tx_status_i (tx_status_o),
    .rx_pop_o    (rx_pop),
    .rx_flush_o  (rx_flush),
    .rx_head_i   (rx_head),
    .rx_status_i (rx_status_o),
    .tx_thld_o   (tx_thld),
    .rx_thld_o   (rx_thld)
  );

  // Software pushes, controller pops
  tti_queue u_tx_queue (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .push_i   (tx_push),
    .wdata_i  (tx_wdata),
    .pop_i    (tx_rready_i),
    .rdata_o  (tx_rdata_o),
    .flush_i  (tx_flush),
    .thld_i   (tx_thld),
    .status_o (tx_status_o)
  );

  // Controller pushes, software pops
  tti_queue u_rx_queue (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .push_i   (rx_wvalid_i),
    .wdata_i  (rx_wdata_i),
    .pop_i    (rx_pop),
    .rdata_o  (rx_head),
    .flush_i  (rx_flush),
    .thld_i   (rx_thld),
    .status_o (rx_status_o)
  );

  assign tx_rvalid_o = !tx_status_o.empty;
  assign rx_wready_o = !rx_status_o.full;

endmodule

//--- tests/tti_top_sva.sv
// Handshake and queue status assertions, bound to the TTI top level by the testbench
`timescale 1ns/10ps
`include "tti_config.svh"

module tti_top_sva (
  input logic                         clk_i,
  input logic                         rst_i,
  input logic                         csr_req_valid_i,
  input tti_csr_pkg::csr_req_t        csr_req_i,
  input logic                         csr_req_ready_o,
  input logic                         csr_rsp_valid_o,
  input tti_csr_pkg::csr_rsp_t        csr_rsp_o,
  input logic                         csr_rsp_ready_i,
  input tti_queue_pkg::queue_status_t tx_status_o
);

  int unsigned fail_count;

  // Request held with its payload until the DUT takes it
  req_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    csr_req_valid_i && !csr_req_ready_o |=> csr_req_valid_i && $stable(csr_req_i))
    else begin
      $error("request dropped or changed before it was accepted");
      fail_count++;
    end

  rsp_hold_a: assert property (@(posedge clk_i) disable iff (rst_i)
    csr_rsp_valid_o && !csr_rsp_ready_i |=> csr_rsp_valid_o)
    else begin
      $error("response valid dropped before it was taken");
      fail_count++;
    end

  rsp_stable_a: assert property (@(posedge clk_i) disable iff (rst_i)
    csr_rsp_valid_o && !csr_rsp_ready_i |=> $stable(csr_rsp_o))
    else begin
      $error("response payload changed while waiting");
      fail_count++;
    end

  rsp_reset_a: assert property (@(posedge clk_i) rst_i |=> !csr_rsp_valid_o)
    else begin
      $error("response valid high after reset");
      fail_count++;
    end

  // Depth counter never runs past the queue capacity
  tx_depth_a: assert property (@(posedge clk_i) disable iff (rst_i)
    tx_status_o.depth <= `TTI_QUEUE_DEPTH)
    else begin
      $error("TX queue depth above its capacity");
      fail_count++;
    end

endmodule

//--- tests/tti_top_tb.sv
// Testbench for the TTI data path that drives register and controller traffic against a model
`timescale 1ns/10ps
`include "tti_config.svh"

module tti_top_tb;
  import tti_csr_pkg::*;
  import tti_queue_pkg::*;

  // Traffic takes well under 1000 cycles
  localparam int max_cycles = 4000;
  localparam int depth = `TTI_QUEUE_DEPTH;

  logic          clk_i;
  logic          rst_i;
  logic          csr_req_valid_i;
  csr_req_t      csr_req_i;
  logic          csr_req_ready_o;
  logic          csr_rsp_valid_o;
  csr_rsp_t      csr_rsp_o;
  logic          csr_rsp_ready_i;
  logic          tx_rvalid_o;
  logic          tx_rready_i;
  queue_word_t   tx_rdata_o;
  logic          rx_wvalid_i;
  logic          rx_wready_o;
  queue_word_t   rx_wdata_i;
  queue_status_t tx_status_o;
  queue_status_t rx_status_o;

  logic [31:0] data_lfsr;
  logic [31:0] rdy_lfsr;
  logic        bp_mode;
  int          cycle_count;
  int          checks;
  int          mismatches;
  int          failures;
  csr_rsp_t    exp_rsp;
  csr_rsp_t    exp_q[$];
  queue_word_t tx_model[$];
  queue_word_t rx_model[$];
  logic [31:0] thld_model;
  logic        rnd_wr;
  logic [3:0]  rnd_addr;
  logic [31:0] rnd_data;

  tti_top dut0 (.*);

  bind tti_top tti_top_sva u_sva (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .csr_req_valid_i (csr_req_valid_i),
    .csr_req_i       (csr_req_i),
    .csr_req_ready_o (csr_req_ready_o),
    .csr_rsp_valid_o (csr_rsp_valid_o),
    .csr_rsp_o       (csr_rsp_o),
    .csr_rsp_ready_i (csr_rsp_ready_i),
    .tx_status_o     (tx_status_o)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], data_lfsr[0]};
      data_lfsr = lfsr_next(data_lfsr);
    end
    return v;
  endfunction

  function automatic queue_status_t model_status(input int count,
                                                 input logic [`TTI_THLD_W-1:0] thld);
    queue_status_t s;
    s.depth           = queue_depth_t'(count);
    s.empty           = (count == 0);
    s.full            = (count == depth);
    s.ready_thld_trig = (thld != 0) && (count >= thld);
    return s;
  endfunction

  // Expected response from the register rules and the model state in request order
  function automatic csr_rsp_t predict_rsp(input csr_req_t req);
    csr_rsp_t rsp;
    rsp = '0;
    case (req.addr)
      TX_DATA_PORT: begin
        rsp.err = !req.write || (tx_model.size() == depth);
        if (!rsp.err) tx_model.push_back(req.wdata);
      end
      RX_DATA_PORT: begin
        rsp.err = req.write || (rx_model.size() == 0);
        if (!rsp.err) rsp.rdata = rx_model.pop_front();
      end
      QUEUE_THLD_CTRL: begin
        if (req.write) thld_model = {16'h0, req.wdata[15:0]};
        else rsp.rdata = thld_model;
      end
      RESET_CONTROL: begin
        rsp.err = !req.write;
        if (req.write && req.wdata[0]) tx_model.delete();
        if (req.write && req.wdata[1]) rx_model.delete();
      end
      QUEUE_STATUS: begin
        rsp.err = req.write;
        if (!req.write) begin
          rsp.rdata = {14'h0, tx_model.size() == depth, rx_model.size() == 0,
                       8'(tx_model.size()), 8'(rx_model.size())};
        end
      end
      default: rsp.err = 1'b1;
    endcase
    return rsp;
  endfunction

  task automatic flag_mismatch(input string msg);
    mismatches++;
    $display("MISMATCH at %0d ns: %s", $time, msg);
  endtask

  task automatic flag_failure(input string msg);
    failures++;
    $display("ERROR at %0d ns: %s", $time, msg);
  endtask

  // Called and returns just after a falling edge
  task automatic issue_req(input logic write, input logic [3:0] addr, input logic [31:0] wdata);
    csr_req_valid_i = 1'b1;
    csr_req_i.write = write;
    csr_req_i.addr  = csr_addr_e'(addr);
    csr_req_i.wdata = wdata;
    do @(posedge clk_i); while (csr_req_ready_o !== 1'b1);
    exp_q.push_back(predict_rsp(csr_req_i));
    @(negedge clk_i);
    csr_req_valid_i = 1'b0;
  endtask

  task automatic wait_idle();
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic pop_tx_word();
    queue_word_t exp_word;
    exp_word = tx_model.pop_front();
    checks++;
    if (tx_rvalid_o !== 1'b1 || tx_rdata_o !== exp_word) begin
      flag_mismatch($sformatf("TX head valid=%0b data=%h, expected %h",
                              tx_rvalid_o, tx_rdata_o, exp_word));
    end
    tx_rready_i = 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    tx_rready_i = 1'b0;
  endtask

  task automatic push_rx_word(input queue_word_t word);
    checks++;
    if (rx_wready_o !== (rx_model.size() < depth)) begin
      flag_mismatch($sformatf("RX write ready %0b with model depth %0d",
                              rx_wready_o, rx_model.size()));
    end
    rx_wvalid_i = 1'b1;
    rx_wdata_i  = word;
    @(posedge clk_i);
    @(negedge clk_i);
    rx_wvalid_i = 1'b0;
    if (rx_model.size() < depth) rx_model.push_back(word);
  endtask

  task automatic check_status();
    queue_status_t exp_tx;
    queue_status_t exp_rx;
    exp_tx = model_status(tx_model.size(), thld_model[15:8]);
    exp_rx = model_status(rx_model.size(), thld_model[7:0]);
    checks++;
    if (tx_status_o !== exp_tx) begin
      flag_mismatch($sformatf("TX status %h, expected %h", tx_status_o, exp_tx));
    end
    if (rx_status_o !== exp_rx) begin
      flag_mismatch($sformatf("RX status %h, expected %h", rx_status_o, exp_rx));
    end
    if (tx_rvalid_o !== !exp_tx.empty) begin
      flag_mismatch($sformatf("tx_rvalid_o is %0b with TX depth %0d", tx_rvalid_o,
                              tx_model.size()));
    end
  endtask

  // Mode changes on a rising edge so the ready driver never races it
  task automatic set_backpressure(input logic on);
    @(posedge clk_i);
    bp_mode = on;
    @(negedge clk_i);
  endtask

  task automatic finish_run();
    $display("Summary: %0d checks, %0d mismatches, %0d other errors, %0d assertion failures",
             checks, mismatches, failures, dut0.u_sva.fail_count);
    if (mismatches == 0 && failures == 0 && dut0.u_sva.fail_count == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  always @(negedge clk_i) begin
    if (bp_mode) begin
      csr_rsp_ready_i = rdy_lfsr[0];
      rdy_lfsr = lfsr_next(rdy_lfsr);
    end else begin
      csr_rsp_ready_i = 1'b1;
    end
  end

  // Responses compared in order on the edge where they are taken
  always @(posedge clk_i) begin
    if (!rst_i && csr_rsp_valid_o && csr_rsp_ready_i) begin
      checks++;
      if (exp_q.size() == 0) begin
        flag_failure("a response arrived with no request outstanding");
      end else begin
        exp_rsp = exp_q.pop_front();
        if (csr_rsp_o !== exp_rsp) begin
          flag_mismatch($sformatf("response err=%0b data=%h, expected err=%0b data=%h",
                                  csr_rsp_o.err, csr_rsp_o.rdata, exp_rsp.err, exp_rsp.rdata));
        end
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= max_cycles) begin
      flag_failure("timeout, the run did not finish within the cycle limit");
      finish_run();
    end
  end

  initial begin
    clk_i           = 1'b0;
    rst_i           = 1'b1;
    csr_req_valid_i = 1'b0;
    csr_req_i       = '0;
    csr_rsp_ready_i = 1'b1;
    tx_rready_i     = 1'b0;
    rx_wvalid_i     = 1'b0;
    rx_wdata_i      = '0;
    data_lfsr       = 32'd75;
    rdy_lfsr        = 32'd75;
    bp_mode         = 1'b0;
    thld_model      = '0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;

    checks++;
    if (csr_rsp_valid_o !== 1'b0 || csr_req_ready_o !== 1'b1) begin
      flag_mismatch("register handshake outputs wrong after reset");
    end
    check_status();
    issue_req(1'b0, QUEUE_THLD_CTRL, '0);
    wait_idle();

    // TX path, then past full
    for (int i = 0; i < 5; i++) issue_req(1'b1, TX_DATA_PORT, rand_bits(32));
    wait_idle();
    check_status();
    while (tx_model.size() != 0) pop_tx_word();
    for (int i = 0; i < depth + 2; i++) issue_req(1'b1, TX_DATA_PORT, rand_bits(32));
    wait_idle();
    check_status();
    while (tx_model.size() != 0) pop_tx_word();
    check_status();

    // RX path with reads on both sides of empty
    issue_req(1'b0, RX_DATA_PORT, '0);
    for (int i = 0; i < 6; i++) push_rx_word(rand_bits(32));
    issue_req(1'b0, QUEUE_STATUS, '0);
    for (int i = 0; i < 7; i++) issue_req(1'b0, RX_DATA_PORT, '0);
    wait_idle();
    check_status();

    // Thresholds of 3 on TX and 2 on RX
    issue_req(1'b1, QUEUE_THLD_CTRL, rand_bits(32));
    issue_req(1'b0, QUEUE_THLD_CTRL, '0);
    issue_req(1'b1, QUEUE_THLD_CTRL, 32'h0000_0302);
    wait_idle();
    for (int i = 0; i < 4; i++) begin
      issue_req(1'b1, TX_DATA_PORT, rand_bits(32));
      wait_idle();
      push_rx_word(rand_bits(32));
      check_status();
    end

    // Flush TX alone, then RX alone
    issue_req(1'b1, RESET_CONTROL, 32'h1);
    issue_req(1'b0, QUEUE_STATUS, '0);
    issue_req(1'b1, TX_DATA_PORT, rand_bits(32));
    wait_idle();
    check_status();
    issue_req(1'b1, RESET_CONTROL, 32'h2);
    wait_idle();
    check_status();
    pop_tx_word();

    issue_req(1'b0, TX_DATA_PORT, '0);
    issue_req(1'b1, RX_DATA_PORT, rand_bits(32));
    issue_req(1'b1, QUEUE_STATUS, rand_bits(32));
    issue_req(1'b0, RESET_CONTROL, '0);
    issue_req(1'b1, 4'hc, rand_bits(32));
    issue_req(1'b0, 4'hf, '0);
    wait_idle();

    // Random traffic under response back-pressure
    for (int i = 0; i < 8; i++) push_rx_word(rand_bits(32));
    set_backpressure(1'b1);
    for (int i = 0; i < 60; i++) begin
      rnd_wr   = (rand_bits(1) != '0);
      rnd_addr = 4'(rand_bits(3));
      rnd_data = rand_bits(32);
      issue_req(rnd_wr, rnd_addr, rnd_data);
    end
    wait_idle();
    set_backpressure(1'b0);
    check_status();
    while (tx_model.size() != 0) pop_tx_word();
    check_status();
    repeat (4) @(negedge clk_i);
    finish_run();
  end

endmodule

//--- flist.f
+incdir+include
rtl/tti_csr_pkg.sv
rtl/tti_queue_pkg.sv
rtl/tti_csr_decode.sv
rtl/tti_csr_access.sv
rtl/tti_queue.sv
rtl/tti_top.sv
tests/tti_top_sva.sv
tests/tti_top_tb.sv

//--- Makefile
# Verilator build and run of the TTI testbench; override any variable on the command line
VERILATOR ?= verilator
TOP       ?= tti_top_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0

SRCS    := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS    := $(wildcard include/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
